/* Bender.yml */
package:
  name: macsec_monitor

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/macsec_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/macsec_ctrl.sv
      - rtl/sectag_parser.sv
      - rtl/macsec_monitor.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_macsec_monitor.sv

/* compile.f */
+incdir+rtl
rtl/macsec_pkg.sv
rtl/stream_fifo.sv
rtl/macsec_ctrl.sv
rtl/sectag_parser.sv
rtl/macsec_monitor.sv
test/tb_macsec_monitor.sv

/* rtl/macsec_ctrl.sv */
/*
 * Stream control FSM
 *   drives output valid from the FIFO state
 *   pops the FIFO on each accepted beat
 *   flags the first beat of every frame
 */

`timescale 1ns/1ps
`default_nettype none

module macsec_ctrl (
   input  logic axis_aclk,
   input  logic axis_resetn,
   input  logic fifo_empty,
   input  logic head_tlast,
   input  logic m_axis_tready,
   output logic m_axis_tvalid,
   output logic fifo_pop,
   output logic first_beat
);

   import macsec_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;

   assign m_axis_tvalid = !fifo_empty;
   assign fifo_pop = m_axis_tvalid & m_axis_tready;
   assign first_beat = fifo_pop & (state == ST_DETECT);

   always_comb begin
      next_state = state;
      case (state)
         ST_DETECT: begin
            // Single-beat frames stay in detect
            if (fifo_pop && !head_tlast)
               next_state = ST_COPY;
         end
         ST_COPY: begin
            if (fifo_pop && head_tlast)
               next_state = ST_DETECT;
         end
         default: next_state = ST_DETECT;
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn)
         state <= ST_DETECT;
      else
         state <= next_state;
   end

   // Head beat must stay offered until the sink takes it
   a_valid_held: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid)
      else $error("macsec_ctrl: valid dropped under back-pressure");

endmodule

`default_nettype wire

/* rtl/macsec_monitor.sv */
/*
 * MACsec frame monitor top level
 *   input FIFO, stream control FSM and SecTAG parser
 *   beats pass through unchanged, status on plain ports
 */

`timescale 1ns/1ps
`default_nettype none

module macsec_monitor (
   input  logic                   axis_aclk,
   input  logic                   axis_resetn,
   // Slave stream
   input  macsec_pkg::axis_data_t s_axis_tdata,
   input  macsec_pkg::axis_keep_t s_axis_tkeep,
   input  macsec_pkg::axis_user_t s_axis_tuser,
   input  logic                   s_axis_tlast,
   input  logic                   s_axis_tvalid,
   output logic                   s_axis_tready,
   // Master stream
   output macsec_pkg::axis_data_t m_axis_tdata,
   output macsec_pkg::axis_keep_t m_axis_tkeep,
   output macsec_pkg::axis_user_t m_axis_tuser,
   output logic                   m_axis_tlast,
   output logic                   m_axis_tvalid,
   input  logic                   m_axis_tready,
   // Status
   input  logic                   stat_clear,
   output macsec_pkg::ethertype_t ethertype,
   output macsec_pkg::tci_t       tci,
   output macsec_pkg::slen_t      slen,
   output macsec_pkg::pnum_t      pnum,
   output macsec_pkg::stat_t      icv,
   output macsec_pkg::stat_t      macsec_pkts,
   output macsec_pkg::stat_t      other_pkts
);

   logic fifo_empty;
   logic fifo_pop;
   logic first_beat;

   // FIFO head feeds the master side directly
   stream_fifo u_fifo (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tkeep  (s_axis_tkeep),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .fifo_pop      (fifo_pop),
      .head_tdata    (m_axis_tdata),
      .head_tkeep    (m_axis_tkeep),
      .head_tuser    (m_axis_tuser),
      .head_tlast    (m_axis_tlast),
      .fifo_empty    (fifo_empty)
   );

   macsec_ctrl u_ctrl (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .fifo_empty    (fifo_empty),
      .head_tlast    (m_axis_tlast),
      .m_axis_tready (m_axis_tready),
      .m_axis_tvalid (m_axis_tvalid),
      .fifo_pop      (fifo_pop),
      .first_beat    (first_beat)
   );

   sectag_parser u_parser (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .first_beat  (first_beat),
      .head_tdata  (m_axis_tdata),
      .stat_clear  (stat_clear),
      .ethertype   (ethertype),
      .tci         (tci),
      .slen        (slen),
      .pnum        (pnum),
      .icv         (icv),
      .macsec_pkts (macsec_pkts),
      .other_pkts  (other_pkts)
   );

endmodule

`default_nettype wire

/* rtl/macsec_pkg.sv */
/*
 * Shared types for the MACsec frame monitor
 *   stream beat types, SecTAG field types, status word, FSM states
 */

`default_nettype none

`include "macsec_settings.svh"

package macsec_pkg;

   typedef logic [`MACSEC_DATA_W-1:0]   axis_data_t;
   typedef logic [`MACSEC_DATA_W/8-1:0] axis_keep_t;
   typedef logic [`MACSEC_USER_W-1:0]   axis_user_t;

   typedef logic [15:0] ethertype_t;
   typedef logic [7:0]  tci_t;
   typedef logic [7:0]  slen_t;
   typedef logic [31:0] pnum_t;

   // ICV and frame counters
   typedef logic [31:0] stat_t;

   typedef enum logic {ST_DETECT, ST_COPY} ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/macsec_settings.svh */
/*
 * Build-time settings for the MACsec frame monitor
 *   stream data and sideband widths
 *   FIFO address bits
 *   MACsec EtherType and SecTAG field positions in the first beat
 */

`ifndef MACSEC_SETTINGS_SVH
`define MACSEC_SETTINGS_SVH

// AXI stream widths
`define MACSEC_DATA_W          256
`define MACSEC_USER_W          128

// Four-entry input FIFO
`define MACSEC_FIFO_DEPTH_BITS 2

// EtherType 0x88E5, byte-swapped as it sits on the little-endian bus
`define MACSEC_ETHERTYPE       16'hE588

// Lowest bit of each header field in the first beat
`define MACSEC_ETYPE_LSB       96
`define MACSEC_TCI_LSB         112
`define MACSEC_SLEN_LSB        120
`define MACSEC_PNUM_LSB        128

`endif

/* rtl/sectag_parser.sv */
/*
 * SecTAG parser for the first beat of each frame
 *   EtherType check and TCI, short length, packet number capture
 *   running 8-bit byte sum standing in for the ICV
 *   MACsec and other frame counters with a clear input
 */

`timescale 1ns/1ps
`default_nettype none

`include "macsec_settings.svh"

module sectag_parser (
   input  logic                   axis_aclk,
   input  logic                   axis_resetn,
   input  logic                   first_beat,
   input  macsec_pkg::axis_data_t head_tdata,
   input  logic                   stat_clear,
   output macsec_pkg::ethertype_t ethertype,
   output macsec_pkg::tci_t       tci,
   output macsec_pkg::slen_t      slen,
   output macsec_pkg::pnum_t      pnum,
   output macsec_pkg::stat_t      icv,
   output macsec_pkg::stat_t      macsec_pkts,
   output macsec_pkg::stat_t      other_pkts
);

   import macsec_pkg::*;

   localparam int NUM_BYTES = `MACSEC_DATA_W / 8;

   ethertype_t etype_field;
   logic       is_macsec;
   logic [7:0] byte_sum;

   assign etype_field = head_tdata[`MACSEC_ETYPE_LSB +: $bits(ethertype_t)];
   assign is_macsec = (etype_field == `MACSEC_ETHERTYPE);

   // Previous low ICV byte plus every byte of the beat, mod 256
   always_comb begin
      byte_sum = icv[7:0];
      for (int i = 0; i < NUM_BYTES; i++) begin
         byte_sum = byte_sum + head_tdata[i*8 +: 8];
      end
   end

   // Header fields follow every first beat
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         ethertype <= '0;
         tci       <= '0;
         slen      <= '0;
         pnum      <= '0;
      end else if (first_beat) begin
         ethertype <= etype_field;
         if (is_macsec) begin
            tci  <= head_tdata[`MACSEC_TCI_LSB +: $bits(tci_t)];
            slen <= head_tdata[`MACSEC_SLEN_LSB +: $bits(slen_t)];
            pnum <= head_tdata[`MACSEC_PNUM_LSB +: $bits(pnum_t)];
         end else begin
            tci  <= '0;
            slen <= '0;
            pnum <= '0;
         end
      end
   end

   // Clear takes priority over a frame arriving in the same cycle
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         icv         <= '0;
         macsec_pkts <= '0;
         other_pkts  <= '0;
      end else if (stat_clear) begin
         icv         <= '0;
         macsec_pkts <= '0;
         other_pkts  <= '0;
      end else if (first_beat) begin
         if (is_macsec) begin
            icv         <= {24'h0, byte_sum};
            macsec_pkts <= macsec_pkts + 32'd1;
         end else begin
            icv        <= '0;
            other_pkts <= other_pkts + 32'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/stream_fifo.sv */
/*
 * Fall-through FIFO for AXI stream beats
 *   one entry holds tdata, tkeep, tuser and tlast
 *   head entry visible without read latency
 *   ready while fewer than three entries are held
 */

`timescale 1ns/1ps
`default_nettype none

`include "macsec_settings.svh"

module stream_fifo (
   input  logic                   axis_aclk,
   input  logic                   axis_resetn,
   input  macsec_pkg::axis_data_t s_axis_tdata,
   input  macsec_pkg::axis_keep_t s_axis_tkeep,
   input  macsec_pkg::axis_user_t s_axis_tuser,
   input  logic                   s_axis_tlast,
   input  logic                   s_axis_tvalid,
   output logic                   s_axis_tready,
   input  logic                   fifo_pop,
   output macsec_pkg::axis_data_t head_tdata,
   output macsec_pkg::axis_keep_t head_tkeep,
   output macsec_pkg::axis_user_t head_tuser,
   output logic                   head_tlast,
   output logic                   fifo_empty
);

   import macsec_pkg::*;

   localparam int AW = `MACSEC_FIFO_DEPTH_BITS;
   localparam int DEPTH = 1 << AW;
   localparam logic [AW:0] FILL_LIMIT = (AW+1)'(DEPTH - 1);

   axis_data_t mem_tdata [DEPTH];
   axis_keep_t mem_tkeep [DEPTH];
   axis_user_t mem_tuser [DEPTH];
   logic       mem_tlast [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          wr_en;

   // Keep one spare slot so the upstream sees ready drop early
   assign s_axis_tready = (count < FILL_LIMIT);
   assign wr_en = s_axis_tvalid & s_axis_tready;
   assign fifo_empty = (count == '0);

   assign head_tdata = mem_tdata[rd_ptr];
   assign head_tkeep = mem_tkeep[rd_ptr];
   assign head_tuser = mem_tuser[rd_ptr];
   assign head_tlast = mem_tlast[rd_ptr];

   always_ff @(posedge axis_aclk) begin
      if (wr_en) begin
         mem_tdata[wr_ptr] <= s_axis_tdata;
         mem_tkeep[wr_ptr] <= s_axis_tkeep;
         mem_tuser[wr_ptr] <= s_axis_tuser;
         mem_tlast[wr_ptr] <= s_axis_tlast;
      end
   end

   // Pointers wrap naturally at the power-of-two depth
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, fifo_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_pop_empty: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      fifo_pop |-> !fifo_empty)
      else $error("stream_fifo: pop while empty");

endmodule

`default_nettype wire

/* test/tb_macsec_monitor.sv */
/*
 * Testbench for the MACsec frame monitor
 *   random frames of one to five beats, about half MACsec
 *   random back-pressure with a throttled burst phase
 *   reference model for the status outputs, beat checker, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "macsec_settings.svh"

module tb_macsec_monitor;

   import macsec_pkg::*;

   localparam int NUM_FRAMES = 200;
   localparam int RESET_CYCLES = 16;
   localparam int TIMEOUT_CYCLES = NUM_FRAMES * 5 * 20;

   typedef struct packed {
      axis_data_t tdata;
      axis_keep_t tkeep;
      axis_user_t tuser;
      logic       tlast;
   } beat_t;

   typedef struct packed {
      ethertype_t ethertype;
      tci_t       tci;
      slen_t      slen;
      pnum_t      pnum;
      stat_t      icv;
      stat_t      macsec_pkts;
      stat_t      other_pkts;
   } status_t;

   logic       axis_aclk = 1'b0;
   logic       axis_resetn;
   axis_data_t s_axis_tdata;
   axis_keep_t s_axis_tkeep;
   axis_user_t s_axis_tuser;
   logic       s_axis_tlast;
   logic       s_axis_tvalid;
   logic       s_axis_tready;
   axis_data_t m_axis_tdata;
   axis_keep_t m_axis_tkeep;
   axis_user_t m_axis_tuser;
   logic       m_axis_tlast;
   logic       m_axis_tvalid;
   logic       m_axis_tready;
   logic       stat_clear;
   ethertype_t ethertype;
   tci_t       tci;
   slen_t      slen;
   pnum_t      pnum;
   stat_t      icv;
   stat_t      macsec_pkts;
   stat_t      other_pkts;

   integer  seed = 32'h2466_fb7c;
   beat_t   sent_q[$];
   status_t exp_status = '0;
   logic    in_frame = 1'b0;
   logic    status_due = 1'b0;
   logic    throttle = 1'b0;
   int      data_errors = 0;
   int      status_errors = 0;
   int      other_errors = 0;
   int      tready_drops = 0;

   macsec_monitor DUT (.*);

   always #4 axis_aclk = ~axis_aclk;

   // Expected status after a first beat, from the previous expectation
   function automatic status_t ref_status(input axis_data_t d, input status_t prev);
      status_t    nxt;
      logic [7:0] sum;
      int         i;
      nxt = prev;
      nxt.ethertype = d[`MACSEC_ETYPE_LSB +: 16];
      if (nxt.ethertype == `MACSEC_ETHERTYPE) begin
         sum = prev.icv[7:0];
         for (i = 0; i < 32; i++)
            sum = sum + d[8*i +: 8];
         nxt.tci = d[`MACSEC_TCI_LSB +: 8];
         nxt.slen = d[`MACSEC_SLEN_LSB +: 8];
         nxt.pnum = d[`MACSEC_PNUM_LSB +: 32];
         nxt.icv = {24'h0, sum};
         nxt.macsec_pkts = prev.macsec_pkts + 32'd1;
      end else begin
         nxt.tci = '0;
         nxt.slen = '0;
         nxt.pnum = '0;
         nxt.icv = '0;
         nxt.other_pkts = prev.other_pkts + 32'd1;
      end
      return nxt;
   endfunction

   function automatic axis_data_t random_data();
      axis_data_t d;
      int         w;
      for (w = 0; w < 8; w++)
         d[32*w +: 32] = $random(seed);
      return d;
   endfunction

   task automatic check_value(input string name, input logic [255:0] expected,
                              input logic [255:0] actual, inout int errors);
      assert (actual === expected)
      else begin
         errors++;
         $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic check_status();
      check_value("ethertype", exp_status.ethertype, ethertype, status_errors);
      check_value("tci", exp_status.tci, tci, status_errors);
      check_value("slen", exp_status.slen, slen, status_errors);
      check_value("pnum", exp_status.pnum, pnum, status_errors);
      check_value("icv", exp_status.icv, icv, status_errors);
      check_value("macsec_pkts", exp_status.macsec_pkts, macsec_pkts, status_errors);
      check_value("other_pkts", exp_status.other_pkts, other_pkts, status_errors);
   endtask

   // Holds the beat until the FIFO takes it, then records it
   task automatic send_beat(input axis_data_t d, input logic last);
      s_axis_tdata  <= d;
      s_axis_tkeep  <= $random(seed);
      s_axis_tuser  <= {$random(seed), $random(seed), $random(seed), $random(seed)};
      s_axis_tlast  <= last;
      s_axis_tvalid <= 1'b1;
      @(posedge axis_aclk);
      while (!s_axis_tready)
         @(posedge axis_aclk);
      sent_q.push_back({s_axis_tdata, s_axis_tkeep, s_axis_tuser, s_axis_tlast});
   endtask

   task automatic drain();
      s_axis_tvalid <= 1'b0;
      while (sent_q.size() != 0)
         @(posedge axis_aclk);
      repeat (2) @(posedge axis_aclk);
   endtask

   task automatic pulse_clear();
      drain();
      stat_clear <= 1'b1;
      @(posedge axis_aclk);
      stat_clear <= 1'b0;
      exp_status.icv = '0;
      exp_status.macsec_pkts = '0;
      exp_status.other_pkts = '0;
      @(posedge axis_aclk);
      check_status();
   endtask

   // Sink readiness, mostly low while throttled
   always @(posedge axis_aclk) begin
      if (throttle)
         m_axis_tready <= (($random(seed) & 3) == 0);
      else
         m_axis_tready <= (($random(seed) & 3) != 0);
   end

   always @(posedge axis_aclk) begin : compare
      beat_t exp_beat;
      if (status_due) begin
         status_due = 1'b0;
         check_status();
      end
      if (axis_resetn && !s_axis_tready)
         tready_drops++;
      if (axis_resetn && m_axis_tvalid && m_axis_tready) begin
         assert (sent_q.size() != 0)
         else begin
            other_errors++;
            $display("Output beat at %0t has no matching input beat", $time);
         end
         if (sent_q.size() != 0) begin
            exp_beat = sent_q.pop_front();
            check_value("m_axis_tdata", exp_beat.tdata, m_axis_tdata, data_errors);
            check_value("m_axis_tkeep", exp_beat.tkeep, m_axis_tkeep, data_errors);
            check_value("m_axis_tuser", exp_beat.tuser, m_axis_tuser, data_errors);
            check_value("m_axis_tlast", exp_beat.tlast, m_axis_tlast, data_errors);
            if (!in_frame) begin
               exp_status = ref_status(exp_beat.tdata, exp_status);
               status_due = 1'b1;
            end
            in_frame = !exp_beat.tlast;
         end
      end
   end

   initial begin : stimulus
      int         f;
      int         b;
      int         len;
      int         gap;
      logic       macsec;
      logic       burst;
      axis_data_t d;
      axis_resetn   = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tkeep  = '0;
      s_axis_tuser  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      stat_clear    = 1'b0;
      repeat (RESET_CYCLES) @(posedge axis_aclk);
      axis_resetn <= 1'b1;
      @(posedge axis_aclk);
      check_value("m_axis_tvalid", 1'b0, m_axis_tvalid, other_errors);
      check_value("s_axis_tready", 1'b1, s_axis_tready, other_errors);
      check_status();
      for (f = 0; f < NUM_FRAMES; f++) begin
         if (f == NUM_FRAMES / 2)
            pulse_clear();
         // Back-to-back frames into a slow sink fill the FIFO
         burst = (f >= 40 && f < 70);
         throttle <= burst;
         len = 1 + (($random(seed) & 32'h7fff_ffff) % 5);
         macsec = (($random(seed) & 1) != 0);
         for (b = 0; b < len; b++) begin
            d = random_data();
            if (b == 0 && macsec)
               d[`MACSEC_ETYPE_LSB +: 16] = `MACSEC_ETHERTYPE;
            else if (b == 0 && d[`MACSEC_ETYPE_LSB +: 16] == `MACSEC_ETHERTYPE)
               d[`MACSEC_ETYPE_LSB] = ~d[`MACSEC_ETYPE_LSB];
            send_beat(d, b == len - 1);
            gap = burst ? 0 : ($random(seed) & 3) / 3;
            if (gap != 0) begin
               s_axis_tvalid <= 1'b0;
               @(posedge axis_aclk);
            end
         end
      end
      throttle <= 1'b0;
      drain();
      assert (tready_drops > 0)
      else begin
         other_errors++;
         $display("s_axis_tready never dropped under back-pressure");
      end
      $display("Errors: data %0d, status %0d, other %0d",
               data_errors, status_errors, other_errors);
      if (data_errors + status_errors + other_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial begin : watchdog
      repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge axis_aclk);
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: data %0d, status %0d, other %0d",
               data_errors, status_errors, other_errors);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire
